//--- Bender.yml
package:
  name: mul_cluster

sources:
  - files:
      - hw/mul_pkg.sv
      - hw/mul_issue.sv
      - hw/mul_lane.sv
      - hw/mul_writeback.sv
      - hw/mul_cluster.sv
  - target: test
    files:
      - sim/mul_cluster_assertions.sv
      - sim/tb_mul_cluster.sv

//--- hw/mul_cluster.sv
// ----------------------------------------------------------
// Multiply cluster top, NUM_LANES slots per cycle in,
// one result per cycle out; results are matched by tag
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mul_cluster import mul_pkg::*; (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  logic                        kill_i,
    input  mul_req_t [NUM_LANES-1:0]    req_i,
    output logic                        req_ready_o,
    output mul_res_t                    wb_o,
    input  logic                        wb_ready_i
);

    lane_in_t [NUM_LANES-1:0]  lane_in;
    mul_res_t [NUM_LANES-1:0]  lane_res;
    logic     [WB_CNT_W-1:0]   wb_free;

    mul_issue u_issue (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .kill_i      (kill_i),
        .req_i       (req_i),
        .wb_free_i   (wb_free),
        .req_ready_o (req_ready_o),
        .lane_o      (lane_in)
    );

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        mul_lane u_lane (
            .clk_i  (clk_i),
            .rstn_i (rstn_i),
            .kill_i (kill_i),
            .lane_i (lane_in[g]),
            .res_o  (lane_res[g])
        );
    end

    mul_writeback u_writeback (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .lane_res_i (lane_res),
        .wb_ready_i (wb_ready_i),
        .wb_o       (wb_o),
        .wb_free_o  (wb_free)
    );

endmodule

`default_nettype wire

//--- hw/mul_issue.sv
// ----------------------------------------------------------
// All valid slots are accepted together or not at all
// A word behind a doubleword in the same lane is held back
// one cycle so both lane stages never finish together
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mul_issue import mul_pkg::*; (
    input  logic                            clk_i,
    input  logic                            rstn_i,
    input  logic                            kill_i,
    input  mul_req_t [NUM_LANES-1:0]        req_i,
    input  logic     [WB_CNT_W-1:0]         wb_free_i,
    output logic                            req_ready_o,
    output lane_in_t [NUM_LANES-1:0]        lane_o
);

    function automatic mul_op_t decode_op(input logic [2:0] funct3, input logic is_word);
        mul_op_t op;
        case (funct3)
            F3_MUL:    op = OP_MUL;                  // MUL and MULW
            F3_MULH:   op = is_word ? OP_NONE : OP_MULH;
            F3_MULHSU: op = is_word ? OP_NONE : OP_MULHSU;
            F3_MULHU:  op = is_word ? OP_NONE : OP_MULHU;
            default:   op = OP_NONE;                 // Divide group
        endcase
        return op;
    endfunction

    mul_op_t                slot_op [NUM_LANES];
    logic [NUM_LANES-1:0]   slot_valid;
    logic [NUM_LANES-1:0]   word_hazard;
    logic [NUM_LANES-1:0]   dw_s1_d, dw_s1_q;        // Doubleword sitting in stage one
    logic [WB_CNT_W-1:0]    n_valid;
    logic [WB_CNT_W-1:0]    n_dw_s1;
    logic [WB_CNT_W-1:0]    need;
    logic [WB_CNT_W-1:0]    s1_cnt_q, s2_cnt_q;      // In flight per lane stage

    always_comb begin
        n_valid = '0;
        n_dw_s1 = '0;
        for (int k = 0; k < NUM_LANES; k++) begin
            slot_op[k]     = decode_op(req_i[k].funct3, req_i[k].is_word);
            slot_valid[k]  = req_i[k].valid & (slot_op[k] != OP_NONE);
            word_hazard[k] = slot_valid[k] & req_i[k].is_word & dw_s1_q[k];
            n_valid        = n_valid + WB_CNT_W'(slot_valid[k]);
            n_dw_s1        = n_dw_s1 + WB_CNT_W'(dw_s1_q[k]);
        end
    end

    // Everything in flight lands in the queue, so it must fit next to the new slots
    assign need        = s1_cnt_q + s2_cnt_q + n_valid;
    assign req_ready_o = ~kill_i & ~(|word_hazard) & (wb_free_i >= need);

    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            lane_o[k].valid   = slot_valid[k] & req_ready_o;
            lane_o[k].op      = slot_op[k];
            lane_o[k].is_word = req_i[k].is_word;
            lane_o[k].rd      = req_i[k].rd;
            lane_o[k].tag     = req_i[k].tag;
            lane_o[k].src1    = req_i[k].src1;
            lane_o[k].src2    = req_i[k].src2;
            dw_s1_d[k]        = lane_o[k].valid & ~req_i[k].is_word;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            s1_cnt_q <= '0;
            s2_cnt_q <= '0;
            dw_s1_q  <= '0;
        end else if (kill_i) begin                   // Lanes are flushed on the same edge
            s1_cnt_q <= '0;
            s2_cnt_q <= '0;
            dw_s1_q  <= '0;
        end else begin
            s1_cnt_q <= req_ready_o ? n_valid : '0;
            s2_cnt_q <= n_dw_s1;                     // Doublewords move on to stage two
            dw_s1_q  <= dw_s1_d;
        end
    end

endmodule

`default_nettype wire

//--- hw/mul_lane.sv
// ----------------------------------------------------------
// Two-stage sign/magnitude multiplier, never stalls
// Word ops finish after stage one, doublewords after two
// Relies on issue never placing a word right behind a
// doubleword, since the output mux favours stage one
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mul_lane import mul_pkg::*; (
    input  logic     clk_i,
    input  logic     rstn_i,
    input  logic     kill_i,
    input  lane_in_t lane_i,
    output mul_res_t res_o
);

    localparam int PP_W   = XLEN + WORD_W;           // 64x32 partial product
    localparam int PROD_W = 2 * XLEN;

    // Magnitude of a signed operand; W forms keep only the low word
    function automatic logic [XLEN-1:0] magnitude(input logic [XLEN-1:0] v,
                                                  input logic            word,
                                                  input logic            neg);
        logic [XLEN-1:0] m;
        m = neg ? (~v + 1'b1) : v;
        return word ? {{(XLEN-WORD_W){1'b0}}, m[WORD_W-1:0]} : m;
    endfunction

    logic                sign1, sign2;
    logic                neg1, neg2;
    logic                neg_d;

    // Stage one
    logic                s1_valid_q;
    logic                s1_word_q;
    logic                s1_neg_q;
    mul_op_t             s1_op_q;
    logic [REG_W-1:0]    s1_rd_q;
    logic [TAG_W-1:0]    s1_tag_q;
    logic [XLEN-1:0]     s1_src1_q, s1_src2_q;

    logic [PP_W-1:0]     pp_lo_d, pp_hi_d;
    logic [WORD_W-1:0]   word_val;
    logic [XLEN-1:0]     word_res;

    // Stage two
    logic                s2_valid_q;
    logic                s2_neg_q;
    mul_op_t             s2_op_q;
    logic [REG_W-1:0]    s2_rd_q;
    logic [TAG_W-1:0]    s2_tag_q;
    logic [PP_W-1:0]     pp_lo_q, pp_hi_q;
    logic [PROD_W-1:0]   prod, prod_fix;
    logic [XLEN-1:0]     dw_res;

    // ----------------------------------------------------------
    // Stage one: operand magnitudes and result sign
    // ----------------------------------------------------------
    assign sign1 = lane_i.is_word ? lane_i.src1[WORD_W-1] : lane_i.src1[XLEN-1];
    assign sign2 = lane_i.is_word ? lane_i.src2[WORD_W-1] : lane_i.src2[XLEN-1];

    assign neg1  = sign1 & (lane_i.op inside {OP_MUL, OP_MULH, OP_MULHSU}); // rs1 signed
    assign neg2  = sign2 & (lane_i.op inside {OP_MUL, OP_MULH});            // rs2 signed
    assign neg_d = neg1 ^ neg2;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            s1_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= lane_i.valid & ~kill_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (lane_i.valid) begin
            s1_word_q <= lane_i.is_word;
            s1_neg_q  <= neg_d;
            s1_op_q   <= lane_i.op;
            s1_rd_q   <= lane_i.rd;
            s1_tag_q  <= lane_i.tag;
            s1_src1_q <= magnitude(lane_i.src1, lane_i.is_word, neg1);
            s1_src2_q <= magnitude(lane_i.src2, lane_i.is_word, neg2);
        end
    end

    assign pp_lo_d = s1_src1_q * s1_src2_q[WORD_W-1:0];
    assign pp_hi_d = s1_src1_q * s1_src2_q[XLEN-1:WORD_W];

    // Word exit, both magnitudes fit in 32 bits so the low product is enough
    assign word_val = s1_neg_q ? (~pp_lo_d[WORD_W-1:0] + 1'b1) : pp_lo_d[WORD_W-1:0];
    assign word_res = {{(XLEN-WORD_W){word_val[WORD_W-1]}}, word_val};

    // ----------------------------------------------------------
    // Stage two: partial products, sum and half select
    // ----------------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            s2_valid_q <= 1'b0;
        end else begin
            s2_valid_q <= s1_valid_q & ~s1_word_q & ~kill_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (s1_valid_q && !s1_word_q) begin
            s2_neg_q <= s1_neg_q;
            s2_op_q  <= s1_op_q;
            s2_rd_q  <= s1_rd_q;
            s2_tag_q <= s1_tag_q;
            pp_lo_q  <= pp_lo_d;
            pp_hi_q  <= pp_hi_d;
        end
    end

    assign prod     = {{(PROD_W-PP_W){1'b0}}, pp_lo_q} + {pp_hi_q, {WORD_W{1'b0}}};
    assign prod_fix = s2_neg_q ? (~prod + 1'b1) : prod;
    assign dw_res   = (s2_op_q == OP_MUL) ? prod_fix[XLEN-1:0] : prod_fix[PROD_W-1:XLEN];

    // Output mux, stage one wins; a kill also drops the result leaving now
    always_comb begin
        if (s1_valid_q && s1_word_q) begin
            res_o.valid  = ~kill_i;
            res_o.rd     = s1_rd_q;
            res_o.tag    = s1_tag_q;
            res_o.result = word_res;
        end else begin
            res_o.valid  = s2_valid_q & ~kill_i;
            res_o.rd     = s2_rd_q;
            res_o.tag    = s2_tag_q;
            res_o.result = dw_res;
        end
    end

endmodule

`default_nettype wire

//--- hw/mul_pkg.sv
// ----------------------------------------------------------
// Shared constants and types of the multiply cluster
// Only RV64M multiplies; divides and their W forms decode
// as idle and are never accepted
// ----------------------------------------------------------
`default_nettype none

package mul_pkg;

    localparam int NUM_LANES = 2;                    // Lanes and issue slots per cycle
    localparam int WB_DEPTH  = 8;                    // Writeback queue entries, power of two
    localparam int XLEN      = 64;
    localparam int WORD_W    = 32;                   // Width of the W forms
    localparam int TAG_W     = 6;
    localparam int REG_W     = 5;
    localparam int WB_PTR_W  = $clog2(WB_DEPTH);
    localparam int WB_CNT_W  = $clog2(WB_DEPTH + 1); // Holds 0..WB_DEPTH

    // RISC-V funct3 of the OP / OP-32 multiply group
    localparam logic [2:0] F3_MUL    = 3'b000;
    localparam logic [2:0] F3_MULH   = 3'b001;
    localparam logic [2:0] F3_MULHSU = 3'b010;
    localparam logic [2:0] F3_MULHU  = 3'b011;

    typedef enum logic [2:0] {
        OP_MUL,
        OP_MULH,
        OP_MULHSU,
        OP_MULHU,
        OP_NONE                                      // Idle
    } mul_op_t;

    typedef struct packed {
        logic             valid;
        logic [2:0]       funct3;
        logic             is_word;                   // MULW
        logic [REG_W-1:0] rd;
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  src1;
        logic [XLEN-1:0]  src2;
    } mul_req_t;

    typedef struct packed {
        logic             valid;
        mul_op_t          op;
        logic             is_word;
        logic [REG_W-1:0] rd;
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  src1;
        logic [XLEN-1:0]  src2;
    } lane_in_t;

    typedef struct packed {
        logic             valid;
        logic [REG_W-1:0] rd;
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  result;
    } mul_res_t;

endpackage

`default_nettype wire

//--- hw/mul_writeback.sv
// ----------------------------------------------------------
// Result queue, up to NUM_LANES pushes and one pop per edge
// Never checks for overflow, the issue credit prevents it
// wb_o shows the head entry and holds it while stalled
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mul_writeback import mul_pkg::*; (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  mul_res_t [NUM_LANES-1:0]    lane_res_i,
    input  logic                        wb_ready_i,
    output mul_res_t                    wb_o,
    output logic     [WB_CNT_W-1:0]     wb_free_o
);

    mul_res_t             mem_q [WB_DEPTH];          // Payload only
    logic [WB_PTR_W-1:0]  wr_ptr_q, rd_ptr_q;
    logic [WB_CNT_W-1:0]  count_q;
    logic [WB_PTR_W-1:0]  wr_idx [NUM_LANES];
    logic [WB_CNT_W-1:0]  push_cnt;
    logic                 pop;

    // Slot for each lane, packed in lane order
    always_comb begin
        push_cnt = '0;
        for (int k = 0; k < NUM_LANES; k++) begin
            wr_idx[k] = wr_ptr_q + push_cnt[WB_PTR_W-1:0];
            push_cnt  = push_cnt + WB_CNT_W'(lane_res_i[k].valid);
        end
    end

    assign pop = (count_q != '0) & wb_ready_i;

    always_comb begin
        wb_o       = mem_q[rd_ptr_q];
        wb_o.valid = (count_q != '0);
    end

    // Entry freed by this edge's pop is already counted
    assign wb_free_o = WB_CNT_W'(WB_DEPTH) - count_q + WB_CNT_W'(pop);

    // ----------------------------------------------------------
    // Storage and pointers
    // ----------------------------------------------------------
    always_ff @(posedge clk_i) begin
        for (int k = 0; k < NUM_LANES; k++) begin
            if (lane_res_i[k].valid) begin
                mem_q[wr_idx[k]] <= lane_res_i[k];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            wr_ptr_q <= wr_ptr_q + push_cnt[WB_PTR_W-1:0];   // Wraps, depth is 2^n
            rd_ptr_q <= rd_ptr_q + WB_PTR_W'(pop);
            count_q  <= count_q + push_cnt - WB_CNT_W'(pop);
        end
    end

endmodule

`default_nettype wire

//--- mul_cluster.f
hw/mul_pkg.sv
hw/mul_issue.sv
hw/mul_lane.sv
hw/mul_writeback.sv
hw/mul_cluster.sv
sim/mul_cluster_assertions.sv
sim/tb_mul_cluster.sv

//--- sim/mul_cluster_assertions.sv
// ----------------------------------------------------------
// Protocol checks bound into the multiply cluster
// Latency checks cover lane 0 only, with an idle queue
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mul_cluster_assertions import mul_pkg::*; (
    input logic                        clk_i,
    input logic                        rstn_i,
    input logic                        kill_i,
    input logic                        req_ready_i,
    input logic                        wb_ready_i,
    input mul_res_t                    wb_i,
    input lane_in_t [NUM_LANES-1:0]    lane_in_i,
    input mul_res_t [NUM_LANES-1:0]    lane_res_i
);

    int unsigned          fail_cnt = 0;              // Failed assertion count
    logic [NUM_LANES-1:0] push_v;                    // Lane results entering the queue

    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            push_v[k] = lane_res_i[k].valid;
        end
    end

    a_reset_idle: assert property (@(posedge clk_i)
        $rose(rstn_i) |-> !wb_i.valid && req_ready_i)
    else begin
        $error("wb_o.valid high or req_ready_o low right after reset");
        fail_cnt++;
    end

    // A kill leaves both stages of every lane empty
    a_kill_flush: assert property (@(posedge clk_i) disable iff (!rstn_i)
        kill_i |=> push_v == '0)
    else begin
        $error("lane result emerged on the cycle after a kill");
        fail_cnt++;
    end

    // Head entry holds while the port is stalled
    a_wb_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
        wb_i.valid && !wb_ready_i |=> wb_i.valid && $stable(wb_i))
    else begin
        $error("wb_o changed while wb_ready_i was low");
        fail_cnt++;
    end

    a_word_latency: assert property (@(posedge clk_i) disable iff (!rstn_i)
        lane_in_i[0].valid && lane_in_i[0].is_word && !wb_i.valid && push_v == '0
        ##1 !kill_i
        |=> wb_i.valid && wb_i.tag == $past(lane_in_i[0].tag, 2))
    else begin
        $error("word result missing on wb_o two cycles after issue");
        fail_cnt++;
    end

    // Nothing may land ahead of the doubleword on the following edge either
    a_dw_latency: assert property (@(posedge clk_i) disable iff (!rstn_i)
        lane_in_i[0].valid && !lane_in_i[0].is_word && !wb_i.valid && push_v == '0
        ##1 push_v == '0 && !kill_i ##1 !kill_i
        |=> wb_i.valid && wb_i.tag == $past(lane_in_i[0].tag, 3))
    else begin
        $error("doubleword result missing on wb_o three cycles after issue");
        fail_cnt++;
    end

endmodule

bind mul_cluster mul_cluster_assertions u_assertions (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .kill_i      (kill_i),
    .req_ready_i (req_ready_o),
    .wb_ready_i  (wb_ready_i),
    .wb_i        (wb_o),
    .lane_in_i   (lane_in),
    .lane_res_i  (lane_res)
);

`default_nettype wire

//--- sim/tb_mul_cluster.sv
// ----------------------------------------------------------
// Random RV64M multiplies against a tag scoreboard
// Only legal multiply encodings are sent; tags wrap at 64
// A kill flushes both lane stages, queued results survive
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_mul_cluster import mul_pkg::*; ();

    localparam int N_RAND  = 120;                    // Random groups
    localparam int N_STALL = 5;                      // Groups in the back-pressure test
    localparam int N_KILL  = 8;
    localparam int N_REQ   = 2 * (N_RAND + N_STALL + 2 * N_KILL) + 4;
    localparam int TIMEOUT = 4 * N_REQ + 200;
    localparam int N_TAGS  = 2 ** TAG_W;

    logic                      clk_i = 1'b0;
    logic                      rstn_i, kill_i, wb_ready_i, req_ready_o;
    mul_req_t [NUM_LANES-1:0]  req_i;
    mul_res_t                  wb_o;

    int  seed = 32'hcf3;
    int  cyc = 0;                                    // Rising edges so far
    int  data_errs = 0;
    int  proto_errs = 0;
    int  wb_mode = 0;                                // 0 ready, 1 random, 2 stalled
    int  next_tag = 0;
    int  pend_cnt = 0;

    // Scoreboard, indexed by tag
    bit               pend [N_TAGS];
    bit               killed [N_TAGS];
    bit               exp_dw [N_TAGS];
    int               acc_cyc [N_TAGS];
    logic [XLEN-1:0]  exp_res [N_TAGS];
    logic [REG_W-1:0] exp_rd [N_TAGS];

    mul_cluster u_dut (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .kill_i      (kill_i),
        .req_i       (req_i),
        .req_ready_o (req_ready_o),
        .wb_o        (wb_o),
        .wb_ready_i  (wb_ready_i)
    );

    always #4 clk_i = ~clk_i;

    always @(posedge clk_i) cyc <= cyc + 1;

    always @(posedge clk_i) begin
        #1;
        case (wb_mode)
            0:       wb_ready_i = 1'b1;
            1:       wb_ready_i = ($random(seed) % 4) != 0;   // About 3 in 4
            default: wb_ready_i = 1'b0;
        endcase
    end

    // ----------------------------------------------------------
    // Reference model and scoreboard
    // ----------------------------------------------------------
    function automatic logic [XLEN-1:0] ref_mul(input logic [2:0] f3, input logic w,
                                                input logic [XLEN-1:0] a, b);
        logic [2*XLEN-1:0] ea, eb, p;
        ea = (f3 == F3_MULHU) ? {{XLEN{1'b0}}, a} : {{XLEN{a[XLEN-1]}}, a};
        eb = (f3 == F3_MUL || f3 == F3_MULH) ? {{XLEN{b[XLEN-1]}}, b} : {{XLEN{1'b0}}, b};
        p  = ea * eb;                                // Exact modulo 2^128
        if (w) begin
            return {{32{p[31]}}, p[31:0]};
        end
        return (f3 == F3_MUL) ? p[XLEN-1:0] : p[2*XLEN-1:XLEN];
    endfunction

    task automatic record_accept(input mul_req_t r);
        if (pend[r.tag]) begin
            $display("%0t: tag %0d issued again while still outstanding", $time, r.tag);
            proto_errs++;
        end
        pend[r.tag]    = 1'b1;
        killed[r.tag]  = 1'b0;
        exp_dw[r.tag]  = !r.is_word;
        acc_cyc[r.tag] = cyc + 1;
        exp_res[r.tag] = ref_mul(r.funct3, r.is_word, r.src1, r.src2);
        exp_rd[r.tag]  = r.rd;
        pend_cnt++;
    endtask

    // Kill on edge cyc+1 flushes stage one and doublewords in stage two
    task automatic drop_killed();
        for (int t = 0; t < N_TAGS; t++) begin
            if (pend[t] && (acc_cyc[t] == cyc ||
                            (exp_dw[t] && acc_cyc[t] == cyc - 1))) begin
                pend[t]   = 1'b0;
                killed[t] = 1'b1;
                pend_cnt--;
            end
        end
    endtask

    task automatic check_result(input mul_res_t r);
        if (pend[r.tag]) begin
            if (r.result !== exp_res[r.tag]) begin
                $display("[ERROR] %0t wb_o.result (tag %0d): got %h expected %h",
                         $time, r.tag, r.result, exp_res[r.tag]);
                data_errs++;
            end
            if (r.rd !== exp_rd[r.tag]) begin
                $display("[ERROR] %0t wb_o.rd (tag %0d): got %0d expected %0d",
                         $time, r.tag, r.rd, exp_rd[r.tag]);
                data_errs++;
            end
            pend[r.tag] = 1'b0;
            pend_cnt--;
        end else if (killed[r.tag]) begin
            $display("%0t: tag %0d was flushed by kill but reached wb_o", $time, r.tag);
            proto_errs++;
        end else begin
            $display("%0t: tag %0d reached wb_o without being issued", $time, r.tag);
            proto_errs++;
        end
    endtask

    // Everything is stable half a cycle after the drive point
    always @(negedge clk_i) begin
        if (rstn_i) begin
            if (req_ready_o) begin
                for (int k = 0; k < NUM_LANES; k++) begin
                    if (req_i[k].valid) record_accept(req_i[k]);
                end
            end
            if (kill_i) drop_killed();
            if (wb_o.valid && wb_ready_i) check_result(wb_o);
        end
    end

    // ----------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------
    function automatic logic [XLEN-1:0] rand_operand();
        case ($unsigned($random(seed)) % 8)
            0:       return '0;
            1:       return {1'b1, {(XLEN-1){1'b0}}};    // Most negative
            2:       return 64'h0000_0000_8000_0000;     // Most negative word
            3:       return '1;
            default: return {$random(seed), $random(seed)};
        endcase
    endfunction

    // op 0..3 is funct3 of MUL..MULHU, 4 is MULW, force_op < 0 picks at random
    task automatic drive_group(input logic [NUM_LANES-1:0] mask, input int force_op);
        int op;
        for (int k = 0; k < NUM_LANES; k++) begin
            op = (force_op >= 0) ? force_op : int'($unsigned($random(seed)) % 5);
            req_i[k].valid   = mask[k];
            req_i[k].funct3  = (op == 4) ? F3_MUL : 3'(op);
            req_i[k].is_word = (op == 4);
            req_i[k].rd      = REG_W'($random(seed));
            req_i[k].tag     = TAG_W'(next_tag);
            req_i[k].src1    = rand_operand();
            req_i[k].src2    = rand_operand();
            if (mask[k]) next_tag = (next_tag + 1) % N_TAGS;
        end
    endtask

    task automatic wait_accept();
        @(negedge clk_i);
        while (!req_ready_o) @(negedge clk_i);
        @(posedge clk_i);
        #1;
        for (int k = 0; k < NUM_LANES; k++) begin
            req_i[k].valid = 1'b0;
        end
    endtask

    task automatic wait_idle();
        while (pend_cnt != 0) @(negedge clk_i);
        repeat (2) @(posedge clk_i);
        #1;
    endtask

    task automatic expect_stall(input int n);
        repeat (n) begin
            @(negedge clk_i);
            if (req_ready_o) begin
                $display("%0t: request accepted with a full queue and wb_ready_i low", $time);
                proto_errs++;
            end
        end
    endtask

    initial begin
        int total;
        rstn_i     = 1'b0;
        kill_i     = 1'b0;
        wb_ready_i = 1'b1;
        req_i      = '0;
        repeat (10) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;
        drive_group(2'b11, -1);                      // Both slots together after reset
        wait_accept();

        wb_mode = 1;
        repeat (N_RAND) begin
            drive_group(NUM_LANES'($unsigned($random(seed)) % 3 + 1), -1);
            wait_accept();
        end

        // Latency from an idle queue, word then doubleword
        wb_mode = 0;
        wait_idle();
        drive_group(2'b01, 4);
        wait_accept();
        wait_idle();
        drive_group(2'b01, 0);
        wait_accept();
        wait_idle();

        wb_mode = 2;                                 // Fill the queue with the port stalled
        repeat (N_STALL - 1) begin
            drive_group(2'b11, -1);
            wait_accept();
        end
        drive_group(2'b11, -1);
        expect_stall(20);
        wb_mode = 1;
        wait_accept();

        for (int i = 0; i < N_KILL; i++) begin
            drive_group(2'b11, -1);
            wait_accept();
            kill_i = 1'b1;
            drive_group(2'b11, -1);                  // Offered during the kill
            @(posedge clk_i);
            #1;
            kill_i = 1'b0;
            wait_accept();
        end
        wait_idle();

        total = data_errs + proto_errs + u_dut.u_assertions.fail_cnt;
        $display("errors: %0d data, %0d protocol, %0d assertion",
                 data_errs, proto_errs, u_dut.u_assertions.fail_cnt);
        if (total == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        wait (cyc >= TIMEOUT);
        $display("timeout after %0d cycles, %0d results outstanding", cyc, pend_cnt);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire
